//--- hw/pager_pkg.sv
package pager_pkg;

	////////////////////////////////////////////////////////////////////////////
	// z80 bus types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// page number held by one window register
	typedef logic [7:0]  page_t;

	////////////////////////////////////////////////////////////////////////////
	// memory layout
	////////////////////////////////////////////////////////////////////////////

	// four 16k windows over the 64k cpu space
	localparam int NUM_WIN = 4;
	localparam int WIN_AW  = 14;

	// physical ram is page and window offset side by side
	localparam int RAM_AW  = 22;

	// rom chip page lines, bit 1 doubles as the dos line
	localparam int ROMPG_W = 5;

	////////////////////////////////////////////////////////////////////////////
	// i/o ports and dos entry
	////////////////////////////////////////////////////////////////////////////

	// low address byte, high bits a[15:14] pick the window
	localparam zdata_t PORT_PAGE_LO = 8'hF7;
	localparam zdata_t PORT_FLAG_LO = 8'h77;

	// opcode fetch from 3Dxx enters the dos rom
	localparam zdata_t DOS_ENTRY_HI = 8'h3D;

	// window i comes out of reset on page i
	localparam page_t [NUM_WIN-1:0] RESET_PAGE = {
		page_t'(3),
		page_t'(2),
		page_t'(1),
		page_t'(0)
	};

endpackage

//--- hw/zcycle_if.sv
`timescale 1ns/1ps

interface zcycle_if import pager_pkg::*; ();

	// single fclk pulse per i/o write cycle
	logic   port_wr;

	// high for as long as the i/o read strobe lasts
	logic   port_rd;

	// single fclk pulse per opcode fetch (m1 with mreq)
	logic   fetch;

	// bus contents taken at the start of the cycle
	zaddr_t addr;
	zdata_t data;

	modport src (
		output port_wr,
		output port_rd,
		output fetch,
		output addr,
		output data
	);

	modport dst (
		input port_wr,
		input port_rd,
		input fetch,
		input addr,
		input data
	);

endinterface

//--- hw/zbus_sync.sv
`timescale 1ns/1ps

module zbus_sync import pager_pkg::*; #(
	parameter int SYNC_STAGES = 2
) (
	input  logic   fclk,
	input  logic   rst,

	input  zaddr_t a,
	input  zdata_t d_in,
	input  logic   iorq_n,
	input  logic   mreq_n,
	input  logic   rd_n,
	input  logic   wr_n,
	input  logic   m1_n,

	zcycle_if.src  bus
);

	typedef struct packed {
		logic iorq_n;
		logic mreq_n;
		logic rd_n;
		logic wr_n;
		logic m1_n;
	} strobes_t;

	strobes_t strb_sync [SYNC_STAGES];
	strobes_t strb;

	logic wr_act;
	logic rd_act;
	logic mf_act;
	logic wr_act_d;
	logic rd_act_d;
	logic mf_act_d;

	logic wr_start;
	logic rd_start;
	logic mf_start;

	////////////////////////////////////////////////////////////////////////////
	// strobe synchronizers, all five strobes move as one word
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			for (int k = 0; k < SYNC_STAGES; k++)
				strb_sync[k] <= '1;
		end
		else
		begin
			strb_sync[0] <= {iorq_n, mreq_n, rd_n, wr_n, m1_n};
			for (int k = 1; k < SYNC_STAGES; k++)
				strb_sync[k] <= strb_sync[k-1];
		end
	end

	assign strb = strb_sync[SYNC_STAGES-1];

	// combine strobe pairs in a flop so a skew between them can not glitch
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			wr_act   <= 1'b0;
			rd_act   <= 1'b0;
			mf_act   <= 1'b0;
			wr_act_d <= 1'b0;
			rd_act_d <= 1'b0;
			mf_act_d <= 1'b0;
		end
		else
		begin
			wr_act   <= !strb.iorq_n && !strb.wr_n;
			rd_act   <= !strb.iorq_n && !strb.rd_n;
			mf_act   <= !strb.mreq_n && !strb.m1_n;
			wr_act_d <= wr_act;
			rd_act_d <= rd_act;
			mf_act_d <= mf_act;
		end
	end

	assign wr_start = wr_act && !wr_act_d;
	assign rd_start = rd_act && !rd_act_d;
	assign mf_start = mf_act && !mf_act_d;

	////////////////////////////////////////////////////////////////////////////
	// events out
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			bus.port_wr <= 1'b0;
			bus.port_rd <= 1'b0;
			bus.fetch   <= 1'b0;
		end
		else
		begin
			bus.port_wr <= wr_start;
			bus.port_rd <= rd_act;
			bus.fetch   <= mf_start;
		end
	end

	// z80 holds address and data steady while the strobe is low
	always_ff @(posedge fclk)
	begin
		if (wr_start || rd_start || mf_start)
		begin
			bus.addr <= a;
			bus.data <= d_in;
		end
	end

	// an i/o write and an opcode fetch are separate machine cycles
	assert property (@(posedge fclk) disable iff (rst) !(bus.port_wr && bus.fetch));

endmodule

//--- hw/window_pager.sv
`timescale 1ns/1ps

module window_pager import pager_pkg::*; (
	input  logic                 fclk,
	input  logic                 rst,

	zcycle_if.dst                bus,

	output page_t  [NUM_WIN-1:0] page,
	output logic   [NUM_WIN-1:0] romnram,

	output zdata_t               d_out,
	output logic                 d_oe
);

	// window 0 starts as rom, the rest as ram
	localparam logic [NUM_WIN-1:0] RESET_ROMNRAM = NUM_WIN'(1);

	page_t [NUM_WIN-1:0]  page_q;
	logic  [NUM_WIN-1:0]  romnram_q;

	logic [$clog2(NUM_WIN)-1:0] win;
	logic                       page_port;
	logic                       flag_port;

	// window number comes from the port's high address bits
	assign win       = bus.addr[WIN_AW +: $clog2(NUM_WIN)];
	assign page_port = bus.addr[7:0] == PORT_PAGE_LO;
	assign flag_port = bus.addr[7:0] == PORT_FLAG_LO;

	////////////////////////////////////////////////////////////////////////////
	// window registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			page_q    <= RESET_PAGE;
			romnram_q <= RESET_ROMNRAM;
		end
		else if (bus.port_wr)
		begin
			if (page_port)
				page_q[win] <= bus.data;
			else if (flag_port)
				romnram_q[win] <= bus.data[0];
		end
	end

	assign page    = page_q;
	assign romnram = romnram_q;

	////////////////////////////////////////////////////////////////////////////
	// readback of the page port
	////////////////////////////////////////////////////////////////////////////

	// addr stays latched for the whole read, so d_out is steady
	assign d_out = page_q[win];
	assign d_oe  = bus.port_rd && page_port;

	// the data bus is never driven under a port write
	assert property (@(posedge fclk) disable iff (rst)
		d_oe |-> !bus.port_wr);

endmodule

//--- hw/dos_ctrl.sv
`timescale 1ns/1ps

module dos_ctrl import pager_pkg::*; (
	input  logic               fclk,
	input  logic               rst,

	zcycle_if.dst              bus,

	input  logic [NUM_WIN-1:0] romnram,

	output logic               dos
);

	typedef enum logic {
		DOS_OFF,
		DOS_ON
	} dos_state_t;

	dos_state_t state;
	dos_state_t state_nxt;

	logic [$clog2(NUM_WIN)-1:0] win;
	logic                       entry_hit;
	logic                       ram_hit;

	assign win = bus.addr[WIN_AW +: $clog2(NUM_WIN)];

	// entry point only counts while the low window shows rom
	assign entry_hit = bus.addr[15:8] == DOS_ENTRY_HI && romnram[0];

	// leaving for code in ram drops the dos rom
	assign ram_hit = !romnram[win];

	always_comb
	begin
		state_nxt = state;
		if (bus.fetch)
		begin
			case (state)
			DOS_OFF:
				if (entry_hit)
					state_nxt = DOS_ON;
			DOS_ON:
				if (ram_hit)
					state_nxt = DOS_OFF;
			default:
				state_nxt = DOS_OFF;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
			state <= DOS_OFF;
		else
			state <= state_nxt;
	end

	assign dos = state == DOS_ON;

endmodule

//--- hw/mem_mapper.sv
`timescale 1ns/1ps

module mem_mapper import pager_pkg::*; (
	input  zaddr_t               a,
	input  logic                 mreq_n,

	input  page_t  [NUM_WIN-1:0] page,
	input  logic   [NUM_WIN-1:0] romnram,
	input  logic                 dos,

	output logic                 csrom,
	output logic                 ram_cs,
	output logic   [ROMPG_W-1:0] rompg,
	output logic   [RAM_AW-1:0]  ram_addr
);

	logic [$clog2(NUM_WIN)-1:0] win;
	page_t                      win_page;
	logic                       win_rom;

	////////////////////////////////////////////////////////////////////////////
	// window lookup straight from the cpu address
	////////////////////////////////////////////////////////////////////////////

	assign win      = a[WIN_AW +: $clog2(NUM_WIN)];
	assign win_page = page[win];
	assign win_rom  = romnram[win];

	// chip selects
	assign csrom  = !mreq_n && win_rom;
	assign ram_cs = !mreq_n && !win_rom;

	// bit 1 carries the inverted dos line and the other bits come from the page
	assign rompg = {win_page[ROMPG_W-1:2], !dos, win_page[0]};

	// ram sees the page on top of the offset inside the window
	assign ram_addr = {win_page, a[WIN_AW-1:0]};

endmodule

//--- hw/pager_top.sv
`timescale 1ns/1ps

module pager_top import pager_pkg::*; #(
	parameter int SYNC_STAGES = 2
) (
	input  logic               fclk,
	input  logic               rst,

	// z80 side
	input  zaddr_t             a,
	input  zdata_t             d_in,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,

	output zdata_t             d_out,
	output logic               d_oe,

	// memory side
	output logic               dos,
	output logic               csrom,
	output logic               ram_cs,
	output logic [ROMPG_W-1:0] rompg,
	output logic [RAM_AW-1:0]  ram_addr
);

	zcycle_if cyc ();

	page_t [NUM_WIN-1:0] page;
	logic  [NUM_WIN-1:0] romnram;

	////////////////////////////////////////////////////////////////////////////
	// bus events
	////////////////////////////////////////////////////////////////////////////

	zbus_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) zbus_sync (
		.fclk  (fclk),
		.rst   (rst),
		.a     (a),
		.d_in  (d_in),
		.iorq_n(iorq_n),
		.mreq_n(mreq_n),
		.rd_n  (rd_n),
		.wr_n  (wr_n),
		.m1_n  (m1_n),
		.bus   (cyc.src)
	);

	////////////////////////////////////////////////////////////////////////////
	// paging state
	////////////////////////////////////////////////////////////////////////////

	window_pager window_pager (
		.fclk   (fclk),
		.rst    (rst),
		.bus    (cyc.dst),
		.page   (page),
		.romnram(romnram),
		.d_out  (d_out),
		.d_oe   (d_oe)
	);

	dos_ctrl dos_ctrl (
		.fclk   (fclk),
		.rst    (rst),
		.bus    (cyc.dst),
		.romnram(romnram),
		.dos    (dos)
	);

	// address translation
	mem_mapper mem_mapper (
		.a       (a),
		.mreq_n  (mreq_n),
		.page    (page),
		.romnram (romnram),
		.dos     (dos),
		.csrom   (csrom),
		.ram_cs  (ram_cs),
		.rompg   (rompg),
		.ram_addr(ram_addr)
	);

endmodule

//--- test/pager_tb.sv
`timescale 1ns/1ps

module pager_tb import pager_pkg::*; ();

	// bus cycle kinds
	localparam logic [1:0] K_IOWR  = 2'd0;
	localparam logic [1:0] K_IORD  = 2'd1;
	localparam logic [1:0] K_FETCH = 2'd2;
	localparam logic [1:0] K_MEM   = 2'd3;

	// one table row where rnd takes the data byte from the lfsr
	typedef struct packed {
		logic [1:0] kind;
		logic       rnd;
		zaddr_t     addr;
		zdata_t     data;
	} entry_t;

	logic               fclk;
	logic               rst;
	zaddr_t             a;
	zdata_t             d_in;
	logic               iorq_n;
	logic               mreq_n;
	logic               rd_n;
	logic               wr_n;
	logic               m1_n;
	zdata_t             d_out;
	logic               d_oe;
	logic               dos;
	logic               csrom;
	logic               ram_cs;
	logic [ROMPG_W-1:0] rompg;
	logic [RAM_AW-1:0]  ram_addr;

	entry_t stim[$];
	logic   stim_ready;
	logic [7:0] lfsr;
	int     fail_count;

	// reference model of the paging state
	page_t              m_page [NUM_WIN];
	logic [NUM_WIN-1:0] m_rom;
	logic               m_dos;

	pager_top #(
		.SYNC_STAGES(2)
	) uut (
		.fclk    (fclk),
		.rst     (rst),
		.a       (a),
		.d_in    (d_in),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.dos     (dos),
		.csrom   (csrom),
		.ram_cs  (ram_cs),
		.rompg   (rompg),
		.ram_addr(ram_addr)
	);

	initial fclk = 1'b0;

	always #4 fclk = !fclk;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// wait n rising edges and then 1 ns into the cycle
	task automatic step(input int n);
		repeat (n) @(posedge fclk);
		#1;
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			fail_count++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// fibonacci lfsr with taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		logic fb;
		fb = s[7] ^ s[5] ^ s[4] ^ s[3];
		return {s[6:0], fb};
	endfunction

	task automatic random_byte(output zdata_t v);
		v = '0;
		for (int k = 0; k < 8; k++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic add(input logic [1:0] kind, input zaddr_t addr, input zdata_t data,
		input logic rnd);
		entry_t e;
		e.kind = kind;
		e.rnd  = rnd;
		e.addr = addr;
		e.data = data;
		stim.push_back(e);
	endtask

	// one memory read in every window at the same offset
	task automatic add_sweep(input logic [WIN_AW-1:0] ofs);
		for (int w = 0; w < NUM_WIN; w++)
			add(K_MEM, {2'(w), ofs}, 8'h00, 1'b0);
	endtask

	task automatic build_table();
		// reset mapping
		add_sweep(14'h0123);
		// page port writes with random pages
		add(K_IOWR, 16'h40F7, 8'h00, 1'b1);
		add_sweep(14'h2A55);
		add(K_IOWR, 16'hC0F7, 8'h00, 1'b1);
		add_sweep(14'h3FFF);
		add(K_IOWR, 16'h80F7, 8'h00, 1'b1);
		add_sweep(14'h0000);
		// readback where the last one is not the page port
		add(K_IORD, 16'h00F7, 8'h00, 1'b0);
		add(K_IORD, 16'h40F7, 8'h00, 1'b0);
		add(K_IORD, 16'h80F7, 8'h00, 1'b0);
		add(K_IORD, 16'hC0F7, 8'h00, 1'b0);
		add(K_IORD, 16'h4077, 8'h00, 1'b0);
		// rom/ram flags
		add(K_IOWR, 16'h8077, 8'h01, 1'b0);
		add(K_MEM,  16'h9000, 8'h00, 1'b0);
		add(K_IOWR, 16'h0077, 8'hFE, 1'b0);
		add(K_MEM,  16'h1000, 8'h00, 1'b0);
		add(K_IOWR, 16'h0077, 8'h01, 1'b0);
		add_sweep(14'h1234);
		// dos entry and exit
		add(K_FETCH, 16'h3D2F, 8'h00, 1'b0);
		add(K_MEM,   16'h0100, 8'h00, 1'b0);
		add(K_FETCH, 16'h0200, 8'h00, 1'b0);
		add(K_FETCH, 16'h8000, 8'h00, 1'b0);
		add(K_FETCH, 16'h4000, 8'h00, 1'b0);
		add(K_IOWR,  16'h0077, 8'h00, 1'b0);
		add(K_FETCH, 16'h3D00, 8'h00, 1'b0);
		add(K_IOWR,  16'h0077, 8'h01, 1'b0);
		add(K_FETCH, 16'h3D10, 8'h00, 1'b0);
		add(K_FETCH, 16'hC123, 8'h00, 1'b0);
		add_sweep(14'h0ABC);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model and per-entry checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_mapping(input zaddr_t addr);
		logic [1:0] w;
		page_t      pg;
		w  = addr[15:14];
		pg = m_page[w];
		check("csrom", 32'(csrom), 32'(m_rom[w]));
		check("ram_cs", 32'(ram_cs), 32'(!m_rom[w]));
		// each page spans 16k of physical ram
		check("ram_addr", 32'(ram_addr), 32'(pg) * 32'h4000 + 32'(addr[13:0]));
		// rompg bit 1 is the inverted dos line
		check("rompg", 32'(rompg), (32'(pg) & 32'h1D) | (m_dos ? 32'd0 : 32'd2));
	endtask

	task automatic update_model(input entry_t e);
		logic [1:0] w;
		w = e.addr[15:14];
		case (e.kind)
		K_IOWR:
			if (e.addr[7:0] == 8'hF7)
				m_page[w] = e.data;
			else if (e.addr[7:0] == 8'h77)
				m_rom[w] = e.data[0];
		K_FETCH:
			if (!m_dos && e.addr[15:8] == 8'h3D && m_rom[0])
				m_dos = 1'b1;
			else if (m_dos && !m_rom[w])
				m_dos = 1'b0;
		default:
			;
		endcase
	endtask

	// strobes low for 8 cycles and high for 8
	task automatic run_entry(input entry_t e);
		a    = e.addr;
		d_in = e.data;
		case (e.kind)
		K_IOWR:
		begin
			iorq_n = 1'b0;
			wr_n   = 1'b0;
		end
		K_IORD:
		begin
			iorq_n = 1'b0;
			rd_n   = 1'b0;
		end
		K_FETCH:
		begin
			m1_n   = 1'b0;
			mreq_n = 1'b0;
			rd_n   = 1'b0;
		end
		default:
		begin
			mreq_n = 1'b0;
			rd_n   = 1'b0;
		end
		endcase
		// the fetch has not reached dos yet
		step(3);
		if (e.kind == K_MEM || e.kind == K_FETCH)
			check_mapping(e.addr);
		step(4);
		if (e.kind == K_IORD && e.addr[7:0] == 8'hF7)
		begin
			check("d_oe", 32'(d_oe), 32'd1);
			check("d_out", 32'(d_out), 32'(m_page[e.addr[15:14]]));
		end
		else
			check("d_oe", 32'(d_oe), 32'd0);
		step(1);
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		step(8);
		update_model(e);
		check("dos", 32'(dos), 32'(m_dos));
		check("d_oe idle", 32'(d_oe), 32'd0);
		check("csrom idle", 32'(csrom), 32'd0);
		check("ram_cs idle", 32'(ram_cs), 32'd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		entry_t e;
		zdata_t rnd_data;
		rst        = 1'b1;
		a          = '0;
		d_in       = '0;
		iorq_n     = 1'b1;
		mreq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		lfsr       = 8'd84;
		fail_count = 0;
		stim_ready = 1'b0;
		for (int i = 0; i < NUM_WIN; i++)
			m_page[i] = page_t'(i);
		m_rom = 4'b0001;
		m_dos = 1'b0;
		build_table();
		stim_ready = 1'b1;
		repeat (5) @(posedge fclk);
		#1;
		rst = 1'b0;
		step(2);
		check("dos after reset", 32'(dos), 32'd0);
		check("d_oe after reset", 32'(d_oe), 32'd0);
		foreach (stim[i])
		begin
			e = stim[i];
			if (e.rnd)
			begin
				random_byte(rnd_data);
				e.data = rnd_data;
			end
			run_entry(e);
		end
		if (fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		int unsigned limit;
		wait (stim_ready);
		limit = stim.size() * 16 + 5 + 100;
		repeat (limit) @(posedge fclk);
		$display("Timeout: the test did not finish within %0d clock cycles", limit);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- vlog.f
hw/pager_pkg.sv
hw/zcycle_if.sv
hw/zbus_sync.sv
hw/window_pager.sv
hw/dos_ctrl.sv
hw/mem_mapper.sv
hw/pager_top.sv
test/pager_tb.sv

//--- run.sh
#!/bin/sh
# compile and run pager_tb with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module pager_tb -Mdir "$OBJ" -o pager_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"$OBJ/pager_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
